/* src/opl_op_pkg.sv */
package opl_op_pkg;

        // Operator input widths
        localparam int PHASE_W = 10;
        localparam int ATT_W   = 10;

        // One log-sine unit is 1/256 of a factor of two
        localparam int LOGSIN_W = 12;

        // Attenuation sum in log units
        localparam int LOGSUM_W = 13;

        // Exponent table word and address of both tables
        localparam int EXP_W      = 10;
        localparam int EXP_ADDR_W = 8;
        localparam int ROM_DEPTH  = 1 << EXP_ADDR_W;

        // Signed output sample
        localparam int SAMPLE_W = 12;

        // Split of the sum into integer octaves and fraction
        localparam int SHIFT_W = LOGSUM_W - EXP_ADDR_W;

        // Largest entries the two tables can hold
        localparam int LOGSIN_MAX = 2137;
        localparam int EXP_MAX    = 1018;

        // Hidden-one magnitude is 11 bits, so this shift clears it
        localparam int SHIFT_ZERO = EXP_W + 1;

        localparam real PI = 3.141592653589793;

        // Sum as seen by the adder (raw) and by the converter (parts)
        typedef union packed {
                logic [LOGSUM_W-1:0] raw;
                struct packed {
                        logic [SHIFT_W-1:0]    shift;
                        logic [EXP_ADDR_W-1:0] frac;
                } parts;
        } log_att_t;

endpackage

/* src/opl_logsin_rom.sv */
`timescale 1ns/1ps

module opl_logsin_rom
(
        input  logic                               clk,
        input  logic                               cen,
        input  logic [opl_op_pkg::EXP_ADDR_W-1:0]  addr,
        input  logic                               mirror,
        output logic [opl_op_pkg::LOGSIN_W-1:0]    logsin
);
        import opl_op_pkg::*;

        logic [LOGSIN_W-1:0]   logsin_tbl [ROM_DEPTH];
        logic [EXP_ADDR_W-1:0] rd_addr;

        // Quarter wave sampled at the middle of each step
        initial
        begin
                real    ph;
                integer val;
                for (int i = 0; i < ROM_DEPTH; i++)
                begin
                        ph  = (real'(i) + 0.5) * PI / 512.0;
                        val = $rtoi(-($ln($sin(ph)) / $ln(2.0)) * 256.0 + 0.5);
                        logsin_tbl[i] = val[LOGSIN_W-1:0];
                end
        end

        // Second quarter runs the table backwards
        assign rd_addr = mirror ? ~addr : addr;

        always_ff @(posedge clk)
        begin
                if (cen)
                begin
                        logsin <= logsin_tbl[rd_addr];
                end
        end

        // Attenuation near zero phase must stay inside the table range
        a_logsin_range: assert property (
                @(posedge clk) cen && !$isunknown(addr) && !$isunknown(mirror)
                |=> logsin <= LOGSIN_W'(LOGSIN_MAX)
        );

endmodule

/* src/opl_exprom.sv */
`timescale 1ns/1ps

module opl_exprom
(
        input  logic                              clk,
        input  logic                              cen,
        input  logic [opl_op_pkg::EXP_ADDR_W-1:0] addr,
        output logic [opl_op_pkg::EXP_W-1:0]      exp
);
        import opl_op_pkg::*;

        // Uncompressed copy of the OPN, OPM and OPL table
        logic [EXP_W-1:0] exp_tbl [ROM_DEPTH];

        // Truncated fractional power of two without the hidden one
        initial
        begin
                real    frac_pow;
                integer val;
                for (int a = 0; a < ROM_DEPTH; a++)
                begin
                        frac_pow = $pow(2.0, real'(ROM_DEPTH - 1 - a) / 256.0);
                        val = $rtoi((frac_pow - 1.0) * 1024.0);
                        exp_tbl[a] = val[EXP_W-1:0];
                end
        end

        always_ff @(posedge clk)
        begin
                if (cen)
                begin
                        exp <= exp_tbl[addr];
                end
        end

        // Address 0 holds the largest entry
        a_exp_range: assert property (
                @(posedge clk) cen && !$isunknown(addr)
                |=> exp <= EXP_W'(EXP_MAX)
        );

endmodule

/* src/opl_op_attn.sv */
`timescale 1ns/1ps

module opl_op_attn
(
        input  logic                             clk,
        input  logic                             rst_n,
        input  logic                             cen,
        input  logic [opl_op_pkg::LOGSIN_W-1:0]  logsin,
        input  logic [opl_op_pkg::ATT_W-1:0]     att,
        input  logic                             sign,
        output opl_op_pkg::log_att_t             att_sum,
        output logic                             sum_sign
);
        import opl_op_pkg::*;

        // One extra bit catches the carry out of the 13-bit sum
        logic [LOGSUM_W:0] sum_full;
        log_att_t          sum_sat;

        // One attenuation step is four log units
        assign sum_full = {2'b00, logsin} + {2'b00, att, 2'b00};

        always_comb
        begin
                if (sum_full[LOGSUM_W])
                begin
                        sum_sat.raw = '1;
                end
                else
                begin
                        sum_sat.raw = sum_full[LOGSUM_W-1:0];
                end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        att_sum  <= '0;
                        sum_sign <= 1'b0;
                end
                else if (cen)
                begin
                        att_sum  <= sum_sat;
                        sum_sign <= sign;
                end
        end

        // Overflow clamps to full attenuation
        a_sum_sat: assert property (
                @(posedge clk) disable iff (!rst_n)
                cen && sum_full[LOGSUM_W] |=> att_sum.raw == '1
        );

endmodule

/* src/opl_op_lin.sv */
`timescale 1ns/1ps

module opl_op_lin
(
        input  logic                                 clk,
        input  logic                                 rst_n,
        input  logic                                 cen,
        input  opl_op_pkg::log_att_t                 att_sum,
        input  logic                                 sum_sign,
        output logic signed [opl_op_pkg::SAMPLE_W-1:0] sample
);
        import opl_op_pkg::*;

        logic [EXP_ADDR_W-1:0] exp_addr;
        logic [EXP_W-1:0]      exp;
        logic [SHIFT_W-1:0]    shift_q;
        logic                  sign_q;
        logic [EXP_W:0]        mag;
        logic [SAMPLE_W-1:0]   mag_ext;

        // Fraction of the octave picks the mantissa
        assign exp_addr = att_sum.parts.frac;

        opl_exprom u_exprom
        (
                .clk  (clk),
                .cen  (cen),
                .addr (exp_addr),
                .exp  (exp)
        );

        // Octave count and sign wait for the ROM read
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        shift_q <= '0;
                        sign_q  <= 1'b0;
                end
                else if (cen)
                begin
                        shift_q <= att_sum.parts.shift;
                        sign_q  <= sum_sign;
                end
        end

        // Hidden one on top of the mantissa and one octave down per shift step
        assign mag     = {1'b1, exp} >> shift_q;
        assign mag_ext = {1'b0, mag};

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        sample <= '0;
                end
                else if (cen)
                begin
                        sample <= sign_q ? -$signed(mag_ext) : $signed(mag_ext);
                end
        end

        // Too many octaves down leaves nothing of the magnitude
        a_shift_zero: assert property (
                @(posedge clk) disable iff (!rst_n)
                cen && shift_q >= SHIFT_W'(SHIFT_ZERO) |=> sample == '0
        );

endmodule

/* src/opl_op_out.sv */
`timescale 1ns/1ps

module opl_op_out
(
        input  logic                                   clk,
        input  logic                                   rst_n,
        input  logic                                   cen,
        input  logic [opl_op_pkg::PHASE_W-1:0]         phase,
        input  logic [opl_op_pkg::ATT_W-1:0]           att,
        output logic signed [opl_op_pkg::SAMPLE_W-1:0] sample
);
        import opl_op_pkg::*;

        logic [LOGSIN_W-1:0] logsin;
        logic [ATT_W-1:0]    att_q;
        logic                sign_q;
        log_att_t            att_sum;
        logic                sum_sign;

        // First stage reads the log-sine of the quarter-wave phase
        opl_logsin_rom u_logsin_rom
        (
                .clk    (clk),
                .cen    (cen),
                .addr   (phase[EXP_ADDR_W-1:0]),
                .mirror (phase[EXP_ADDR_W]),
                .logsin (logsin)
        );

        // Attenuation and half-wave sign follow the ROM read
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        att_q  <= '0;
                        sign_q <= 1'b0;
                end
                else if (cen)
                begin
                        att_q  <= att;
                        sign_q <= phase[PHASE_W-1];
                end
        end

        // Second stage sums in the log domain
        opl_op_attn u_attn
        (
                .clk      (clk),
                .rst_n    (rst_n),
                .cen      (cen),
                .logsin   (logsin),
                .att      (att_q),
                .sign     (sign_q),
                .att_sum  (att_sum),
                .sum_sign (sum_sign)
        );

        // Third and fourth stages do the exponent lookup and the shift and sign
        opl_op_lin u_lin
        (
                .clk      (clk),
                .rst_n    (rst_n),
                .cen      (cen),
                .att_sum  (att_sum),
                .sum_sign (sum_sign),
                .sample   (sample)
        );

endmodule

/* bench/opl_op_tb.sv */
`timescale 1ns/1ps

module opl_op_tb;
        import opl_op_pkg::*;

        localparam int CLK_HALF    = 4;
        localparam int VEC_TOTAL   = 800;
        localparam int WATCHDOG_NS = VEC_TOTAL * 8 * (2 * CLK_HALF) + 1000;

        logic                       clk;
        logic                       rst_n;
        logic                       cen;
        logic [PHASE_W-1:0]         phase;
        logic [ATT_W-1:0]           att;
        logic signed [SAMPLE_W-1:0] sample;

        // Inputs taken at each enabled edge with the oldest first
        logic [PHASE_W-1:0] ph_q [$];
        logic [ATT_W-1:0]   at_q [$];
        logic               chk_q [$];

        logic                       tracked;
        logic                       pending;
        logic                       pend_chk;
        logic [PHASE_W-1:0]         pend_ph;
        logic [ATT_W-1:0]           pend_at;
        logic                       en_seen;
        logic signed [SAMPLE_W-1:0] last_sample;
        logic signed [SAMPLE_W-1:0] expv;
        logic signed [SAMPLE_W-1:0] seen [1 << PHASE_W];

        int errors;
        int checks;
        int outstanding;
        int err_base;
        int chk_base;
        int sym_pts [5] = '{0, 37, 128, 200, 255};

        opl_op_out u_dut
        (
                .clk    (clk),
                .rst_n  (rst_n),
                .cen    (cen),
                .phase  (phase),
                .att    (att),
                .sample (sample)
        );

        always #CLK_HALF clk = ~clk;

        // Rounded quarter-wave log-sine
        function automatic int log_sine(input int idx);
                real s;
                s = $sin((real'(idx) + 0.5) * PI / 512.0);
                return $rtoi($floor(-$log10(s) / $log10(2.0) * 256.0 + 0.5));
        endfunction

        // Truncated mantissa without the hidden one
        function automatic int exp_mantissa(input int fr);
                return $rtoi(($pow(2.0, real'(255 - fr) / 256.0) - 1.0) * 1024.0);
        endfunction

        function automatic logic signed [SAMPLE_W-1:0] ref_sample(
                input logic [PHASE_W-1:0] ph,
                input logic [ATT_W-1:0]   at
        );
                int idx;
                int sum;
                int sh;
                int mag;
                idx = ph[8] ? 255 - int'(ph[7:0]) : int'(ph[7:0]);
                sum = log_sine(idx) + 4 * int'(at);
                if (sum > 8191)
                begin
                        sum = 8191;
                end
                sh  = sum / 256;
                mag = (sh >= 11) ? 0 : (1024 + exp_mantissa(sum % 256)) >> sh;
                if (ph[9])
                begin
                        mag = -mag;
                end
                return SAMPLE_W'(mag);
        endfunction

        // Record what the DUT samples and release each entry four enabled edges later
        always @(posedge clk)
        begin
                en_seen = rst_n && cen;
                if (en_seen)
                begin
                        ph_q.push_back(phase);
                        at_q.push_back(att);
                        chk_q.push_back(tracked);
                        if (ph_q.size() == 4)
                        begin
                                pend_ph  = ph_q.pop_front();
                                pend_at  = at_q.pop_front();
                                pend_chk = chk_q.pop_front();
                                pending  = 1'b1;
                        end
                end
        end

        always @(negedge clk)
        begin
                if (pending)
                begin
                        pending = 1'b0;
                        if (pend_chk)
                        begin
                                expv = ref_sample(pend_ph, pend_at);
                                checks++;
                                outstanding--;
                                seen[pend_ph] = sample;
                                if (sample !== expv)
                                begin
                                        $display("Error: sample got %h expected %h (phase %h att %h)",
                                                 sample, expv, pend_ph, pend_at);
                                        errors++;
                                end
                        end
                end
                else if (rst_n && !en_seen && sample !== last_sample)
                begin
                        $display("Hold failure: sample moved from %h to %h while cen was low",
                                 last_sample, sample);
                        errors++;
                end
                last_sample = sample;
        end

        task automatic apply(
                input logic [PHASE_W-1:0] ph,
                input logic [ATT_W-1:0]   at,
                input logic               en
        );
                phase   <= ph;
                att     <= at;
                cen     <= en;
                tracked <= 1'b1;
                if (en)
                begin
                        outstanding++;
                end
                @(posedge clk);
        endtask

        // Push untracked items until every tracked one has come out
        task automatic drain();
                while (outstanding != 0)
                begin
                        cen     <= 1'b1;
                        tracked <= 1'b0;
                        @(posedge clk);
                end
                cen <= 1'b0;
        endtask

        task automatic report(input string name);
                $display("Test %s: %0d checks, %0d errors", name, checks - chk_base,
                         errors - err_base);
                chk_base = checks;
                err_base = errors;
        endtask

        initial
        begin
                int idx;
                int ls;
                int k;
                logic found;
                logic signed [SAMPLE_W-1:0] s0, s1, s2, s3;
                clk         = 1'b0;
                rst_n       = 1'b0;
                cen         = 1'b0;
                phase       = '0;
                att         = '0;
                tracked     = 1'b0;
                pending     = 1'b0;
                pend_chk    = 1'b0;
                en_seen     = 1'b0;
                last_sample = '0;
                errors      = 0;
                checks      = 0;
                outstanding = 0;
                err_base    = 0;
                chk_base    = 0;
                void'($urandom(32'hb49c_72ca));

                repeat (2) @(posedge clk);
                rst_n <= 1'b1;
                @(posedge clk);
                @(negedge clk);
                checks++;
                if (sample !== '0)
                begin
                        $display("Error: sample got %h expected %h after reset", sample, 12'h000);
                        errors++;
                end
                @(posedge clk);
                report("reset");

                // Pick phase and att so that the sum lands on every fraction at shift 0
                for (int f = 0; f < 256; f++)
                begin
                        found = 1'b0;
                        idx   = 0;
                        ls    = 0;
                        for (int i = 255; i >= 0; i--)
                        begin
                                if (!found && log_sine(i) <= f && (f - log_sine(i)) % 4 == 0)
                                begin
                                        found = 1'b1;
                                        idx   = i;
                                        ls    = log_sine(i);
                                end
                        end
                        apply(PHASE_W'(idx), ATT_W'((f - ls) / 4), 1'b1);
                end
                drain();
                report("exp_sweep");

                for (int n = 0; n < 5; n++)
                begin
                        k = sym_pts[n];
                        for (int q = 0; q < 4; q++)
                        begin
                                apply(PHASE_W'(q * 256 + k), '0, 1'b1);
                                apply(PHASE_W'(q * 256 + 255 - k), '0, 1'b1);
                        end
                end
                drain();
                // Points at equal distance from the peak in all four quarters
                for (int n = 0; n < 5; n++)
                begin
                        k  = sym_pts[n];
                        s0 = seen[PHASE_W'(k)];
                        s1 = seen[PHASE_W'(511 - k)];
                        s2 = seen[PHASE_W'(512 + k)];
                        s3 = seen[PHASE_W'(1023 - k)];
                        checks++;
                        if (!(s0 > 0 && s1 == s0 && s2 == -s0 && s3 == -s0))
                        begin
                                $display("Mirror failure: samples %h %h %h %h at offset %0d differ",
                                         s0, s1, s2, s3, k);
                                errors++;
                        end
                end
                report("sign_mirror");

                // Shift count crosses 11 at att 704 with the peak phase
                for (int a = 690; a < 720; a++)
                begin
                        apply(PHASE_W'(255), ATT_W'(a), 1'b1);
                end
                for (int n = 0; n < 16; n++)
                begin
                        apply(PHASE_W'($urandom), ATT_W'(704 + $urandom % 320), 1'b1);
                end
                for (int q = 0; q < 4; q++)
                begin
                        apply(PHASE_W'(q * 256 + 255), ATT_W'(1023), 1'b1);
                end
                drain();
                report("attenuation");

                for (int n = 0; n < 400; n++)
                begin
                        apply(PHASE_W'($urandom), ATT_W'($urandom), ($urandom % 2) == 1);
                end
                drain();
                report("random_cen");

                $display("Done: %0d checks, %0d errors", checks, errors);
                if (errors == 0)
                begin
                        $display("Simulation finished: PASS");
                end
                else
                begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

        initial
        begin
                #(WATCHDOG_NS);
                $display("Watchdog expired before all tests finished");
                $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

/* sources.f */
src/opl_op_pkg.sv
src/opl_logsin_rom.sv
src/opl_exprom.sv
src/opl_op_attn.sv
src/opl_op_lin.sv
src/opl_op_out.sv
bench/opl_op_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the operator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module opl_op_tb -f sources.f -o opl_op_sim \
        && ./obj_dir/opl_op_sim > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
        && { echo "Result: failed"; exit 1; } \
        || { echo "Result: passed"; exit 0; }
